/* Makefile */
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= test passed

SRCS := $(shell cat vlog.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* src/lsu_issue.sv */
/*
  Issue side of the load/store unit. Purely combinational.
  Forms the address, refuses accesses that cross a word boundary,
  builds byte enables and lane-rotated write data, and drives the bus request.
  A granted request pushes its control into the transaction queue.
*/

`timescale 1ns/1ps

module lsu_issue (
  // Request from the execute stage
  input  logic                        req_valid_i,
  input  logic                        req_we_i,
  input  lsu_pkg::lsu_size_e          req_size_i,
  input  logic                        req_signed_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_base_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_offset_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_wdata_i,
  output logic                        req_ready_o,
  output logic                        misaligned_o,

  // Memory bus request channel
  output logic                        data_req_o,
  input  logic                        data_gnt_i,
  output logic [lsu_pkg::XLEN-1:0]    data_addr_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::XLEN-1:0]    data_wdata_o,
  output logic                        data_we_o,

  // Control toward the queue
  lsu_txn_if.issue                    txn
);

  logic [lsu_pkg::XLEN-1:0]   eff_addr;   // Base plus offset
  logic [lsu_pkg::OFFS_W-1:0] byte_off;   // Low address bits
  logic                       addr_misal; // Access would cross a word
  logic [lsu_pkg::BE_W-1:0]   be_base;    // Enables before the lane shift
  lsu_pkg::lsu_word_u         wdata_in;
  lsu_pkg::lsu_word_u         wdata_rot;

  ////////////////////////////////////////////////////////////////////////////
  // Address and alignment
  ////////////////////////////////////////////////////////////////////////////

  assign eff_addr = req_base_i + req_offset_i;
  assign byte_off = eff_addr[lsu_pkg::OFFS_W-1:0];

  always_comb
  begin
    case (req_size_i)
      lsu_pkg::SIZE_BYTE: addr_misal = 1'b0;            // Bytes always fit
      lsu_pkg::SIZE_HALF: addr_misal = (byte_off == '1); // Half at lane 3 spills over
      default:            addr_misal = (byte_off != '0); // Word needs lane 0
    endcase
  end

  // Word address goes out, lanes are picked by the enables
  assign data_addr_o = {eff_addr[lsu_pkg::XLEN-1:lsu_pkg::OFFS_W], {lsu_pkg::OFFS_W{1'b0}}};

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables and write data
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_size_i)
      lsu_pkg::SIZE_BYTE: be_base = 4'b0001;
      lsu_pkg::SIZE_HALF: be_base = 4'b0011;
      default:            be_base = 4'b1111;
    endcase
  end

  // Shift up to the first addressed lane; a legal access never drops bits
  assign data_be_o = be_base << byte_off;

  assign wdata_in = req_wdata_i;

  // Rotate left by the offset in bytes so lane 0 of the operand lands on byte_off
  always_comb
  begin
    for (int i = 0; i < lsu_pkg::NUM_BYTES; i++)
    begin
      wdata_rot.b[i] = wdata_in.b[lsu_pkg::OFFS_W'(i) - byte_off]; // Index wraps mod 4
    end
  end

  assign data_wdata_o = wdata_rot;
  assign data_we_o    = req_we_i;

  ////////////////////////////////////////////////////////////////////////////
  // Bus request and handshake
  ////////////////////////////////////////////////////////////////////////////

  assign misaligned_o = req_valid_i && addr_misal;

  // Queue space is a registered flag, no path from the response strobe
  assign data_req_o  = req_valid_i && !addr_misal && txn.space;
  assign req_ready_o = data_req_o && data_gnt_i;  // Grant equals acceptance

  // Push control of the accepted access
  assign txn.push   = req_ready_o;
  assign txn.we     = req_we_i;
  assign txn.size   = req_size_i;
  assign txn.sign   = req_signed_i;
  assign txn.offset = byte_off;

endmodule

/* src/lsu_load_align.sv */
/*
  Load result extraction. Picks the addressed byte or half out of the
  response word, extends it with zeros or its sign bit, and registers it.
  The result appears one cycle after the response, for loads only.
*/

`timescale 1ns/1ps

module lsu_load_align (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i,  // Raw bus read data

  lsu_resp_if.align                resp,

  output logic                     load_valid_o,
  output logic [lsu_pkg::XLEN-1:0] load_data_o
);

  lsu_pkg::lsu_word_u       rdata_u;
  lsu_pkg::lsu_word_u       rdata_sh;    // Addressed lane moved down to lane 0
  logic [7:0]               byte_sel;
  logic [15:0]              half_sel;
  logic [lsu_pkg::XLEN-1:0] rdata_ext;   // Extended result, before the register
  logic                     load_valid_q;
  logic [lsu_pkg::XLEN-1:0] load_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Lane select and extension
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_u  = data_rdata_i;
  assign rdata_sh = data_rdata_i >> {resp.offset, 3'b000};
  assign byte_sel = rdata_u.b[resp.offset];
  assign half_sel = rdata_sh.h[0];   // Lane pair from the offset up, offset 3 refused at issue

  always_comb
  begin
    case (resp.size)
      lsu_pkg::SIZE_BYTE: rdata_ext = {{24{resp.sign & byte_sel[7]}}, byte_sel};
      lsu_pkg::SIZE_HALF: rdata_ext = {{16{resp.sign & half_sel[15]}}, half_sel};
      default:            rdata_ext = rdata_u;   // Word passes through
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      load_valid_q <= 1'b0;
    else
      load_valid_q <= resp.valid && !resp.we;   // Stores give no result
  end

  // Data held between loads
  always_ff @(posedge clk)
  begin
    if (resp.valid && !resp.we)
      load_data_q <= rdata_ext;
  end

  assign load_valid_o = load_valid_q;
  assign load_data_o  = load_data_q;

endmodule

/* src/lsu_pkg.sv */
/*
  Shared widths and types for the load/store unit.
  Every RTL file refers to these by scoped name (lsu_pkg::...).
  The data word union gives byte-lane and half-lane views of one bus word.
*/

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN      = 32;         // Data and address width
  localparam int NUM_BYTES = XLEN / 8;   // Byte lanes per word
  localparam int BE_W      = NUM_BYTES;  // One enable per lane
  localparam int OFFS_W    = 2;          // Byte offset inside a word

  ////////////////////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10   // 2'b11 is unused, treated as word
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Data word, two lane views
  ////////////////////////////////////////////////////////////////////////////

  // Lane 0 is the least significant byte or half
  typedef union packed {
    logic [NUM_BYTES-1:0][7:0]      b;   // Byte lanes
    logic [NUM_BYTES/2-1:0][15:0]   h;   // Half lanes
  } lsu_word_u;

endpackage

/* src/lsu_resp_if.sv */
/*
  Response strobe plus control of the oldest outstanding transaction,
  from the transaction queue to load alignment.
  The head entry is retired at the end of every cycle with valid high.
*/

`timescale 1ns/1ps

interface lsu_resp_if;

  logic                       valid;   // Copy of the bus response strobe
  logic                       we;      // Head is a store, no result
  lsu_pkg::lsu_size_e         size;
  logic                       sign;
  logic [lsu_pkg::OFFS_W-1:0] offset;  // Lane select for extraction

  // Queue side
  modport queue (output valid, output we, output size, output sign, output offset);

  // Alignment side
  modport align (input valid, input we, input size, input sign, input offset);

endinterface

/* src/lsu_top.sv */
/*
  Load/store unit top level.
  Issue feeds the memory bus and the transaction queue; the queue hands
  the oldest control to load alignment when each response comes back.
  DEPTH sets the number of outstanding bus transactions.
*/

`timescale 1ns/1ps

module lsu_top #(
  parameter int DEPTH = 2   // Outstanding transaction limit
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // Request from the execute stage
  input  logic                        req_valid_i,
  input  logic                        req_we_i,
  input  lsu_pkg::lsu_size_e          req_size_i,
  input  logic                        req_signed_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_base_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_offset_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_wdata_i,
  output logic                        req_ready_o,
  output logic                        misaligned_o,   // Access refused

  // Memory bus
  output logic                        data_req_o,
  input  logic                        data_gnt_i,
  output logic [lsu_pkg::XLEN-1:0]    data_addr_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::XLEN-1:0]    data_wdata_o,
  output logic                        data_we_o,
  input  logic                        data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]    data_rdata_i,

  // Load result, one cycle after its response
  output logic                        load_valid_o,
  output logic [lsu_pkg::XLEN-1:0]    load_data_o,

  output logic                        busy_o          // Transactions outstanding
);

  lsu_txn_if  txn_if ();   // Issue to queue
  lsu_resp_if resp_if ();  // Queue to alignment

  lsu_issue u_issue (
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .req_size_i   (req_size_i),
    .req_signed_i (req_signed_i),
    .req_base_i   (req_base_i),
    .req_offset_i (req_offset_i),
    .req_wdata_i  (req_wdata_i),
    .req_ready_o  (req_ready_o),
    .misaligned_o (misaligned_o),
    .data_req_o   (data_req_o),
    .data_gnt_i   (data_gnt_i),
    .data_addr_o  (data_addr_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .data_we_o    (data_we_o),
    .txn          (txn_if)
  );

  lsu_txn_queue #(
    .DEPTH (DEPTH)
  ) u_txn_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_rvalid_i (data_rvalid_i),
    .busy_o        (busy_o),
    .txn           (txn_if),
    .resp          (resp_if)
  );

  lsu_load_align u_load_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_rdata_i (data_rdata_i),
    .resp         (resp_if),
    .load_valid_o (load_valid_o),
    .load_data_o  (load_data_o)
  );

endmodule

/* src/lsu_txn_if.sv */
/*
  Control of each granted transaction, from issue to the transaction queue.
  Issue pushes only while the queue reports space.
*/

`timescale 1ns/1ps

interface lsu_txn_if;

  logic                      push;    // Transaction granted this cycle
  logic                      we;      // Store when high
  lsu_pkg::lsu_size_e        size;
  logic                      sign;    // Sign-extend the load result
  logic [lsu_pkg::OFFS_W-1:0] offset; // Byte offset of the access
  logic                      space;   // Queue below DEPTH entries

  // Issue side
  modport issue (output push, output we, output size, output sign, output offset,
                 input space);

  // Queue side
  modport queue (input push, input we, input size, input sign, input offset,
                 output space);

endinterface

/* src/lsu_txn_queue.sv */
/*
  In-order queue of outstanding transaction control.
  One entry is written per grant and retired per bus response.
  The occupancy count limits outstanding accesses to DEPTH and drives busy.
*/

`timescale 1ns/1ps

module lsu_txn_queue #(
  parameter int DEPTH = 2   // Maximum outstanding transactions, 1 or more
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     data_rvalid_i,  // Bus response, one per grant, in order
  output logic     busy_o,

  lsu_txn_if.queue txn,
  lsu_resp_if.queue resp
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);   // Holds 0 .. DEPTH

  // Entry storage, written at grant
  logic                       we_q     [DEPTH];
  lsu_pkg::lsu_size_e         size_q   [DEPTH];
  logic                       sign_q   [DEPTH];
  logic [lsu_pkg::OFFS_W-1:0] offset_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;   // Outstanding transactions

  // Circular increment, wraps after the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (txn.push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (data_rvalid_i)
        rd_ptr_q <= ptr_inc(rd_ptr_q);   // Head retired this cycle

      case ({txn.push, data_rvalid_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;      // Idle, or push and pop together
      endcase
    end
  end

  // Entry write, no reset on stored control
  always_ff @(posedge clk)
  begin
    if (txn.push)
    begin
      we_q[wr_ptr_q]     <= txn.we;
      size_q[wr_ptr_q]   <= txn.size;
      sign_q[wr_ptr_q]   <= txn.sign;
      offset_q[wr_ptr_q] <= txn.offset;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status and head
  ////////////////////////////////////////////////////////////////////////////

  // Registered count only, a same-cycle response frees nothing early
  assign txn.space = (count_q < CNT_W'(DEPTH));
  assign busy_o    = (count_q != '0);

  assign resp.valid  = data_rvalid_i;
  assign resp.we     = we_q[rd_ptr_q];
  assign resp.size   = size_q[rd_ptr_q];
  assign resp.sign   = sign_q[rd_ptr_q];
  assign resp.offset = offset_q[rd_ptr_q];

endmodule

/* verification/lsu_tb.sv */
/*
  Testbench for the load/store unit. Runs directed and random accesses
  against a 64-word memory model with random grant stalls and response delays.
  Bus fields are checked at grant and load results against a reference model.
*/

`timescale 1ns/1ps

module lsu_tb;

  localparam int DEPTH       = 2;
  localparam int NUM_ACC     = 80;                 // Directed plus random accesses
  localparam int CYCLE_LIMIT = 40 * NUM_ACC + 16;  // 40 per access plus reset

  logic               clk;
  logic               rst_n;
  logic               req_valid_i;
  logic               req_we_i;
  lsu_pkg::lsu_size_e req_size_i;
  logic               req_signed_i;
  logic [31:0]        req_base_i;
  logic [31:0]        req_offset_i;
  logic [31:0]        req_wdata_i;
  logic               req_ready_o;
  logic               misaligned_o;
  logic               data_req_o;
  logic               data_gnt_i;
  logic [31:0]        data_addr_o;
  logic [3:0]         data_be_o;
  logic [31:0]        data_wdata_o;
  logic               data_we_o;
  logic               data_rvalid_i;
  logic [31:0]        data_rdata_i;
  logic               load_valid_o;
  logic [31:0]        load_data_o;
  logic               busy_o;

  logic [31:0] lfsr_state = 32'hda26_aad0;
  logic [31:0] mem [64];          // Memory model, word indexed
  logic [31:0] exp_q [$];         // Expected load results, grant order
  logic [31:0] rsp_data_q [$];    // Read data captured at grant
  logic        rsp_load_q [$];    // Response belongs to a load
  int          rsp_due_q [$];     // Cycle in which each response is driven
  int          outstanding = 0;   // Grants minus responses
  int          grant_count = 0;
  int          legal_count = 0;   // Accesses that should reach the bus

  lsu_top #(.DEPTH(DEPTH)) u_lsu_top (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "check failed");
  endtask

  // Galois LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      r[i] = lfsr_state[0];
    end
    return r;
  endfunction

  function automatic logic [3:0] lane_enables(input lsu_pkg::lsu_size_e size,
                                              input logic [1:0] off);
    case (size)
      lsu_pkg::SIZE_BYTE: return 4'b0001 << off;
      lsu_pkg::SIZE_HALF: return 4'b0011 << off;
      default:            return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int i = 0; i < 4; i++)
      m[8*i +: 8] = {8{be[i]}};
    return m;
  endfunction

  // Operand lane 0 lands on the addressed lane
  function automatic logic [31:0] rotate_lanes(input logic [31:0] w, input logic [1:0] off);
    logic [63:0] d;
    d = {w, w} << (8 * off);
    return d[63:32];
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] word, input logic [1:0] off,
                                                input lsu_pkg::lsu_size_e size, input logic sgn);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(word >> (8 * off));
    h = 16'(word >> (8 * off));   // Two lanes from the addressed one up
    case (size)
      lsu_pkg::SIZE_BYTE: return {{24{sgn & b[7]}}, b};
      lsu_pkg::SIZE_HALF: return {{16{sgn & h[15]}}, h};
      default:            return word;
    endcase
  endfunction

  task automatic do_access(input logic we, input lsu_pkg::lsu_size_e size, input logic sgn,
                           input logic [31:0] base, input logic [31:0] offs,
                           input logic [31:0] wdata);
    req_valid_i  = 1'b1;
    req_we_i     = we;
    req_size_i   = size;
    req_signed_i = sgn;
    req_base_i   = base;
    req_offset_i = offs;
    req_wdata_i  = wdata;
    @(posedge clk);
    while (!req_ready_o)   // Held through grant stalls and a full queue
      @(posedge clk);
    #2;
    req_valid_i = 1'b0;
    legal_count++;
  endtask

  // Misaligned request, seen for one cycle and withdrawn
  task automatic do_refused(input lsu_pkg::lsu_size_e size, input logic [31:0] base,
                            input logic [31:0] offs);
    req_valid_i  = 1'b1;
    req_we_i     = 1'b0;
    req_size_i   = size;
    req_base_i   = base;
    req_offset_i = offs;
    @(posedge clk);
    assert (misaligned_o && !data_req_o)
      else report_error($sformatf("misaligned access at %h not refused", base + offs));
    #2;
    req_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("test failed");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : bus_model
    logic [31:0] eff;
    logic [31:0] rnd;
    logic [31:0] mask;
    logic        load_due;   // Load response taken at the previous edge
    int          idx;
    int          due;
    int          last_due;
    int          cyc;
    for (int i = 0; i < 64; i++)
      mem[i] = {8'(i) ^ 8'h5a, 8'(i) + 8'h81, ~8'(i), 8'(i)};  // Mixed sign lanes
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    cyc           = 0;
    last_due      = -1;
    load_due      = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(posedge clk);
      cyc++;
      assert (load_valid_o == load_due)
        else report_error($sformatf("load_valid_o %b, expected %b", load_valid_o, load_due));
      assert (busy_o == (outstanding != 0))
        else report_error($sformatf("busy_o %b with %0d outstanding", busy_o, outstanding));
      load_due = 1'b0;
      if (data_rvalid_i)   // Response taken this edge
      begin
        void'(rsp_data_q.pop_front());
        void'(rsp_due_q.pop_front());
        load_due = rsp_load_q.pop_front();
        outstanding--;
      end
      if (data_req_o && data_gnt_i)
      begin
        eff  = req_base_i + req_offset_i;
        idx  = int'(eff[7:2]);
        mask = lane_mask(lane_enables(req_size_i, eff[1:0]));
        assert (data_addr_o == {eff[31:2], 2'b00} && data_we_o == req_we_i && !misaligned_o)
          else report_error($sformatf("bus address %h we %b misaligned %b for %h",
                                      data_addr_o, data_we_o, misaligned_o, eff));
        assert (data_be_o == lane_enables(req_size_i, eff[1:0]))
          else report_error($sformatf("byte enables %b wrong for %h", data_be_o, eff));
        if (req_we_i)
        begin
          assert (((data_wdata_o ^ rotate_lanes(req_wdata_i, eff[1:0])) & mask) == '0)
            else report_error($sformatf("write data %h wrong for %h", data_wdata_o, eff));
          mem[idx] = (mem[idx] & ~mask) | (rotate_lanes(req_wdata_i, eff[1:0]) & mask);
        end
        else
          exp_q.push_back(expected_load(mem[idx], eff[1:0], req_size_i, req_signed_i));
        rnd = rand_bits(2);
        due = cyc + int'(rnd[1:0]);   // One to four cycles after the grant
        if (due <= last_due)
          due = last_due + 1;         // In order, one per cycle
        last_due = due;
        rsp_due_q.push_back(due);
        rsp_data_q.push_back(mem[idx]);
        rsp_load_q.push_back(!req_we_i);
        outstanding++;
        grant_count++;
      end
      assert (outstanding <= DEPTH)
        else report_error($sformatf("%0d transactions outstanding", outstanding));
      rnd = rand_bits(2);
      #2;
      data_gnt_i    = (rnd[1:0] != 2'b00);   // Grant three cycles in four
      data_rvalid_i = (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc);
      data_rdata_i  = data_rvalid_i ? rsp_data_q[0] : '0;
    end
  end

  // Load results in grant order
  initial
  begin : result_check
    logic [31:0] exp;
    forever
    begin
      @(posedge clk);
      if (load_valid_o)
      begin
        assert (exp_q.size() > 0) else report_error("load result with no load outstanding");
        exp = exp_q.pop_front();
        assert (load_data_o == exp)
          else report_error($sformatf("load data %h, expected %h", load_data_o, exp));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0]        rnd;
    logic [31:0]        w;
    lsu_pkg::lsu_size_e sz;
    logic [1:0]         off;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_size_i   = lsu_pkg::SIZE_WORD;
    req_signed_i = 1'b0;
    req_base_i   = '0;
    req_offset_i = '0;
    req_wdata_i  = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    assert (!load_valid_o && !busy_o && !data_req_o)
      else report_error("outputs not idle after reset");
    #2;
    for (int k = 0; k < 4; k++)   // Word store, word load back
    begin
      w = rand_bits(32);
      do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h30 + 32'(8 * k), 32'h4, w);
      do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h34 + 32'(8 * k), 32'h0, 32'h0);
    end
    for (int k = 0; k < 4; k++)   // Byte stores, whole word read back
    begin
      w = rand_bits(32);
      do_access(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, 32'h80, 32'(k), w);
      do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h80, 32'h0, 32'h0);
    end
    for (int k = 0; k < 3; k++)
    begin
      w = rand_bits(32);
      do_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h84, 32'(k), w);
      do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h84, 32'h0, 32'h0);
    end
    for (int s = 0; s < 2; s++)   // Every legal offset, zero then sign extension
    begin
      for (int k = 0; k < 4; k++)
        do_access(1'b0, lsu_pkg::SIZE_BYTE, 1'(s), 32'ha0, 32'(k), 32'h0);
      for (int k = 0; k < 3; k++)
        do_access(1'b0, lsu_pkg::SIZE_HALF, 1'(s), 32'ha4, 32'(k), 32'h0);
    end
    for (int k = 1; k < 4; k++)
      do_refused(lsu_pkg::SIZE_WORD, 32'h20, 32'(k));
    do_refused(lsu_pkg::SIZE_HALF, 32'h21, 32'h2);
    for (int k = 0; k < 40; k++)  // Random mix over 16 words
    begin
      rnd = rand_bits(10);
      sz  = (rnd[2:1] == 2'b11) ? lsu_pkg::SIZE_WORD : lsu_pkg::lsu_size_e'(rnd[2:1]);
      off = (sz == lsu_pkg::SIZE_WORD) ? 2'b00 : rnd[4:3];
      if (sz == lsu_pkg::SIZE_HALF && off == 2'b11)
        off = 2'b10;
      w = rand_bits(32);
      do_access(rnd[0], sz, rnd[5], {26'h0, rnd[9:6], 2'b00}, {30'h0, off}, w);
    end
    while (rsp_due_q.size() > 0 || exp_q.size() > 0)
      @(posedge clk);
    repeat (4)
    begin
      @(posedge clk);
      assert (!busy_o && !data_req_o)
        else report_error("busy or request high after last response");
    end
    assert (grant_count == legal_count && outstanding == 0)
      else report_error($sformatf("%0d grants for %0d accesses", grant_count, legal_count));
    $display("test passed");
    $finish;
  end

endmodule

/* vlog.f */
src/lsu_pkg.sv
src/lsu_txn_if.sv
src/lsu_resp_if.sv
src/lsu_issue.sv
src/lsu_txn_queue.sv
src/lsu_load_align.sv
src/lsu_top.sv
verification/lsu_tb.sv
